// File: cpu_pkg.sv
package cpu_pkg;

    // Opcodes of the instruction set. Codes 8 to 14 are not assigned and run as no-ops.
    typedef enum logic [3:0] {
        OP_JMP  = 4'd0,
        OP_LOD  = 4'd1,
        OP_STR  = 4'd2,
        OP_ADD  = 4'd3,
        OP_ADDI = 4'd4,
        OP_LODI = 4'd5,
        OP_NAND = 4'd6,
        OP_JEQZ = 4'd7,
        OP_HLT  = 4'd15
    } op_e;

    // The byte at the lower address is the high byte of the instruction.
    // The address or immediate is {reg1, reg2}.
    // Raw opcode bits are kept so that unassigned codes pass through unchanged.
    typedef struct packed {
        logic [3:0] op;
        logic [3:0] reg0;
        logic [3:0] reg1;
        logic [3:0] reg2;
    } inst_t;

    // One job for the execute unit. STR carries its store data in val1.
    typedef struct packed {
        op_e        op;
        logic [3:0] rd;
        logic [7:0] val1;
        logic [7:0] val2;
        logic [7:0] addr;
    } exec_req_t;

    typedef struct packed {
        logic [3:0] rd;
        logic [7:0] value;
        logic       wen;
    } wb_t;

    // A single-byte bus request.
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] wdata;
        logic       we;
    } mem_req_t;

    typedef enum logic [1:0] {
        CTL_IDLE,
        CTL_DECODE,
        CTL_EXEC_WAIT,
        CTL_HALTED
    } ctl_state_e;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_HI,
        FETCH_LO,
        FETCH_FULL
    } fetch_state_e;

endpackage

// File: fetch_unit.sv
module fetch_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_start,
    input  logic              fetch_flush,
    input  logic [7:0]        fetch_pc,
    input  logic              inst_ready,
    input  logic              bus_ready,
    input  logic [7:0]        bus_rdata,
    output logic              inst_valid,
    output cpu_pkg::inst_t    inst,
    output logic              bus_valid,
    output cpu_pkg::mem_req_t bus_out
);

    cpu_pkg::fetch_state_e state;
    logic [7:0]            pc_q;
    logic [7:0]            hi_q;
    logic [7:0]            req_addr;
    logic [7:0]            drain_addr;
    logic                  req_active;
    logic                  drain;

    assign req_active = (state == cpu_pkg::FETCH_HI) || (state == cpu_pkg::FETCH_LO);
    assign req_addr   = (state == cpu_pkg::FETCH_LO) ? pc_q + 8'd1 : pc_q;

    // A read cut off by a flush stays on the bus until it completes, then its data is dropped.
    assign bus_valid     = drain || req_active;
    assign bus_out.addr  = drain ? drain_addr : req_addr;
    assign bus_out.wdata = 8'h00;
    assign bus_out.we    = 1'b0;

    assign inst_valid = (state == cpu_pkg::FETCH_FULL);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= cpu_pkg::FETCH_IDLE;
            drain <= 1'b0;
        end else begin
            if (drain && bus_ready) begin
                drain <= 1'b0;
            end else if (fetch_flush && !drain && req_active && !bus_ready) begin
                drain      <= 1'b1;
                drain_addr <= req_addr;
            end

            if (fetch_start) begin
                state <= cpu_pkg::FETCH_HI;
                pc_q  <= fetch_pc;
            end else if (fetch_flush) begin
                state <= cpu_pkg::FETCH_IDLE;
            end else begin
                case (state)
                    cpu_pkg::FETCH_HI: begin
                        if (bus_ready && !drain) begin
                            hi_q  <= bus_rdata;
                            state <= cpu_pkg::FETCH_LO;
                        end
                    end
                    cpu_pkg::FETCH_LO: begin
                        if (bus_ready && !drain) begin
                            inst  <= cpu_pkg::inst_t'({hi_q, bus_rdata});
                            state <= cpu_pkg::FETCH_FULL;
                        end
                    end
                    cpu_pkg::FETCH_FULL: begin
                        if (inst_ready) state <= cpu_pkg::FETCH_IDLE;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: exec_unit.sv
module exec_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                exec_valid,
    input  cpu_pkg::exec_req_t  exec_job,
    input  logic                wb_ready,
    input  logic                bus_ready,
    input  logic [7:0]          bus_rdata,
    output logic                exec_ready,
    output logic                wb_valid,
    output cpu_pkg::wb_t        wb,
    output logic                bus_valid,
    output cpu_pkg::mem_req_t   bus_out
);

    cpu_pkg::exec_req_t job_q;
    logic               mem_busy;
    logic               is_mem;
    logic [7:0]         alu_value;
    logic               alu_wen;

    // One job at a time; a pending writeback blocks the next one.
    assign exec_ready = !wb_valid && !mem_busy;

    assign is_mem = (exec_job.op == cpu_pkg::OP_LOD) || (exec_job.op == cpu_pkg::OP_STR);

    always_comb begin
        alu_value = 8'h00;
        alu_wen   = 1'b1;
        case (exec_job.op)
            cpu_pkg::OP_ADD,
            cpu_pkg::OP_ADDI: alu_value = exec_job.val1 + exec_job.val2;
            cpu_pkg::OP_NAND: alu_value = ~(exec_job.val1 & exec_job.val2);
            cpu_pkg::OP_LODI: alu_value = exec_job.val1;
            default:          alu_wen   = 1'b0;
        endcase
    end

    assign bus_valid     = mem_busy;
    assign bus_out.addr  = job_q.addr;
    assign bus_out.wdata = job_q.val1;
    assign bus_out.we    = (job_q.op == cpu_pkg::OP_STR);

    always_ff @(posedge clk) begin
        if (!rst) begin
            mem_busy <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            if (exec_valid && exec_ready) begin
                if (is_mem) begin
                    job_q    <= exec_job;
                    mem_busy <= 1'b1;
                end else begin
                    wb.rd    <= exec_job.rd;
                    wb.value <= alu_value;
                    wb.wen   <= alu_wen;
                    wb_valid <= 1'b1;
                end
            end else if (mem_busy && bus_ready) begin
                // A store also returns a record so that control knows it finished.
                wb.rd    <= job_q.rd;
                wb.value <= bus_rdata;
                wb.wen   <= (job_q.op == cpu_pkg::OP_LOD);
                wb_valid <= 1'b1;
                mem_busy <= 1'b0;
            end else if (wb_valid && wb_ready) begin
                wb_valid <= 1'b0;
            end
        end
    end

endmodule

// File: mem_arbiter.sv
module mem_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_valid,
    input  cpu_pkg::mem_req_t fetch_out,
    input  logic              exec_valid,
    input  cpu_pkg::mem_req_t exec_out,
    input  logic              mem_ready,
    input  logic [7:0]        mem_rdata,
    output logic              fetch_ready,
    output logic [7:0]        fetch_rdata,
    output logic              exec_ready,
    output logic [7:0]        exec_rdata,
    output logic              mem_req,
    output cpu_pkg::mem_req_t mem_out
);

    // Set when the current grant belongs to the execute unit.
    logic owner_exec;

    // The grant is held while mem_req is high, and a new one is made
    // only once the port is idle again.
    always_ff @(posedge clk) begin
        if (!rst) begin
            mem_req    <= 1'b0;
            owner_exec <= 1'b0;
            mem_out    <= '0;
        end else if (mem_req) begin
            if (mem_ready) mem_req <= 1'b0;
        end else if (exec_valid) begin
            mem_req    <= 1'b1;
            owner_exec <= 1'b1;
            mem_out    <= exec_out;
        end else if (fetch_valid) begin
            mem_req    <= 1'b1;
            owner_exec <= 1'b0;
            mem_out    <= fetch_out;
        end
    end

    // Only the owner sees the handshake and the read data.
    assign exec_ready  = mem_req && owner_exec && mem_ready;
    assign fetch_ready = mem_req && !owner_exec && mem_ready;
    assign exec_rdata  = owner_exec ? mem_rdata : 8'h00;
    assign fetch_rdata = owner_exec ? 8'h00 : mem_rdata;

endmodule

// File: cpu_control.sv
module cpu_control #(
    parameter logic [7:0] RESET_PC = 8'h00
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_valid,
    input  cpu_pkg::inst_t     inst,
    input  logic               exec_ready,
    input  logic               wb_valid,
    input  cpu_pkg::wb_t       wb,
    output logic               fetch_start,
    output logic               fetch_flush,
    output logic [7:0]         fetch_pc,
    output logic               inst_ready,
    output logic               exec_valid,
    output cpu_pkg::exec_req_t exec_job,
    output logic               wb_ready,
    output logic               halted
);

    cpu_pkg::ctl_state_e state;
    cpu_pkg::inst_t      inst_q;
    cpu_pkg::op_e        op;
    cpu_pkg::exec_req_t  job_d;
    logic [7:0]          pc;
    logic [7:0]          regs [16];
    logic [7:0]          imm;
    logic                is_exec;
    logic                take_branch;

    // The program counter points at the next instruction to fetch.
    assign fetch_pc = pc;

    assign op  = cpu_pkg::op_e'(inst_q.op);
    assign imm = {inst_q.reg1, inst_q.reg2};

    assign inst_ready = (state == cpu_pkg::CTL_IDLE);
    assign wb_ready   = (state == cpu_pkg::CTL_EXEC_WAIT);
    assign halted     = (state == cpu_pkg::CTL_HALTED);

    // Decode and operand read.
    always_comb begin
        job_d       = '0;
        job_d.op    = op;
        job_d.rd    = inst_q.reg0;
        is_exec     = 1'b1;
        take_branch = 1'b0;
        case (op)
            cpu_pkg::OP_LOD: job_d.addr = imm;
            cpu_pkg::OP_STR: begin
                job_d.val1 = regs[inst_q.reg0];
                job_d.addr = imm;
            end
            cpu_pkg::OP_ADD,
            cpu_pkg::OP_NAND: begin
                job_d.val1 = regs[inst_q.reg1];
                job_d.val2 = regs[inst_q.reg2];
            end
            // ADDI adds the 8-bit immediate to reg0 in place.
            cpu_pkg::OP_ADDI: begin
                job_d.val1 = regs[inst_q.reg0];
                job_d.val2 = imm;
            end
            cpu_pkg::OP_LODI: job_d.val1 = imm;
            cpu_pkg::OP_JMP: begin
                is_exec     = 1'b0;
                take_branch = 1'b1;
            end
            cpu_pkg::OP_JEQZ: begin
                is_exec     = 1'b0;
                take_branch = (regs[inst_q.reg0] == 8'h00);
            end
            default: is_exec = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= cpu_pkg::CTL_IDLE;
            pc          <= RESET_PC;
            // Held high through reset so the first fetch starts right after release.
            fetch_start <= 1'b1;
            fetch_flush <= 1'b0;
            exec_valid  <= 1'b0;
        end else begin
            fetch_start <= 1'b0;
            fetch_flush <= 1'b0;
            case (state)
                cpu_pkg::CTL_IDLE: begin
                    if (inst_valid) begin
                        inst_q      <= inst;
                        pc          <= pc + 8'd2;
                        fetch_start <= 1'b1;
                        state       <= cpu_pkg::CTL_DECODE;
                    end
                end
                cpu_pkg::CTL_DECODE: begin
                    if (is_exec) begin
                        exec_job   <= job_d;
                        exec_valid <= 1'b1;
                        state      <= cpu_pkg::CTL_EXEC_WAIT;
                    end else if (op == cpu_pkg::OP_HLT) begin
                        fetch_flush <= 1'b1;
                        state       <= cpu_pkg::CTL_HALTED;
                    end else begin
                        if (take_branch) begin
                            pc          <= imm;
                            fetch_flush <= 1'b1;
                            fetch_start <= 1'b1;
                        end
                        state <= cpu_pkg::CTL_IDLE;
                    end
                end
                cpu_pkg::CTL_EXEC_WAIT: begin
                    if (exec_valid && exec_ready) exec_valid <= 1'b0;
                    if (wb_valid) state <= cpu_pkg::CTL_IDLE;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid && wb_ready && wb.wen) begin
            regs[wb.rd] <= wb.value;
        end
    end

endmodule

// File: eightbit_cpu.sv
module eightbit_cpu #(
    parameter logic [7:0] RESET_PC = 8'h00
) (
    input  logic              clk,
    input  logic              rst,
    output logic              mem_req,
    output cpu_pkg::mem_req_t mem_out,
    input  logic              mem_ready,
    input  logic [7:0]        mem_rdata,
    output logic              halted
);

    cpu_pkg::inst_t     inst;
    cpu_pkg::exec_req_t exec_job;
    cpu_pkg::wb_t       wb;
    cpu_pkg::mem_req_t  fetch_out;
    cpu_pkg::mem_req_t  exec_out;
    logic               fetch_start;
    logic               fetch_flush;
    logic [7:0]         fetch_pc;
    logic               inst_valid;
    logic               inst_ready;
    logic               exec_valid;
    logic               exec_ready;
    logic               wb_valid;
    logic               wb_ready;
    logic               fetch_bus_valid;
    logic               fetch_bus_ready;
    logic [7:0]         fetch_bus_rdata;
    logic               exec_bus_valid;
    logic               exec_bus_ready;
    logic [7:0]         exec_bus_rdata;

    cpu_control #(.RESET_PC(RESET_PC)) u_control (
        .clk(clk), .rst(rst),
        .inst_valid(inst_valid), .inst(inst),
        .exec_ready(exec_ready), .wb_valid(wb_valid), .wb(wb),
        .fetch_start(fetch_start), .fetch_flush(fetch_flush), .fetch_pc(fetch_pc),
        .inst_ready(inst_ready), .exec_valid(exec_valid), .exec_job(exec_job),
        .wb_ready(wb_ready), .halted(halted)
    );

    fetch_unit u_fetch (
        .clk(clk), .rst(rst),
        .fetch_start(fetch_start), .fetch_flush(fetch_flush), .fetch_pc(fetch_pc),
        .inst_ready(inst_ready), .bus_ready(fetch_bus_ready), .bus_rdata(fetch_bus_rdata),
        .inst_valid(inst_valid), .inst(inst),
        .bus_valid(fetch_bus_valid), .bus_out(fetch_out)
    );

    exec_unit u_exec (
        .clk(clk), .rst(rst),
        .exec_valid(exec_valid), .exec_job(exec_job), .wb_ready(wb_ready),
        .bus_ready(exec_bus_ready), .bus_rdata(exec_bus_rdata),
        .exec_ready(exec_ready), .wb_valid(wb_valid), .wb(wb),
        .bus_valid(exec_bus_valid), .bus_out(exec_out)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .fetch_valid(fetch_bus_valid), .fetch_out(fetch_out),
        .exec_valid(exec_bus_valid), .exec_out(exec_out),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .fetch_ready(fetch_bus_ready), .fetch_rdata(fetch_bus_rdata),
        .exec_ready(exec_bus_ready), .exec_rdata(exec_bus_rdata),
        .mem_req(mem_req), .mem_out(mem_out)
    );

endmodule

// File: tb_mem.sv
module tb_mem (
    input  logic              clk,
    input  logic              zero_latency,
    input  logic              mem_req,
    input  cpu_pkg::mem_req_t mem_out,
    output logic              mem_ready,
    output logic [7:0]        mem_rdata
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] mem [256];
    logic [7:0] lfsr;
    logic [1:0] wait_left;
    logic       busy;

    // Fibonacci LFSR with taps 8, 6, 5 and 4.
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // Each random bit costs one LFSR step.
    function automatic logic take_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    task automatic fill();
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i) ^ 8'hA5;
        end
    endtask

    task automatic write_byte(input logic [7:0] addr, input logic [7:0] data);
        mem[addr] = data;
    endtask

    function automatic logic [7:0] read_byte(input logic [7:0] addr);
        return mem[addr];
    endfunction

    initial begin
        lfsr      = 8'd82;
        busy      = 1'b0;
        wait_left = 2'd0;
        mem_ready = 1'b0;
        mem_rdata = 8'h00;
    end

    // The port request comes from a register in the DUT, so it is settled
    // 1 ns after the edge. The transfer itself happens on the next edge.
    always @(posedge clk) begin
        #1;
        if (mem_req !== 1'b1) begin
            busy      = 1'b0;
            mem_ready = 1'b0;
        end else begin
            if (!busy) begin
                busy = 1'b1;
                if (zero_latency) begin
                    wait_left = 2'd0;
                end else begin
                    wait_left[1] = take_bit();
                    wait_left[0] = take_bit();
                end
            end else if (wait_left != 2'd0) begin
                wait_left = wait_left - 2'd1;
            end
            if (wait_left == 2'd0) begin
                mem_ready = 1'b1;
                mem_rdata = mem[mem_out.addr];
                if (mem_out.we) begin
                    mem[mem_out.addr] = mem_out.wdata;
                end
            end
        end
    end

endmodule

// File: tb_eightbit.sv
module tb_eightbit;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 2000;

    // Data bytes preloaded for the LOD program.
    localparam logic [7:0] LOD_DATA0 = 8'h3C;
    localparam logic [7:0] LOD_DATA1 = 8'h81;
    localparam logic [7:0] SKIP_PRESET = 8'hEE;

    logic              clk;
    logic              rst;
    logic              zero_latency;
    logic              mem_req;
    cpu_pkg::mem_req_t mem_out;
    logic              mem_ready;
    logic [7:0]        mem_rdata;
    logic              halted;
    logic [7:0]        load_addr;

    eightbit_cpu #(.RESET_PC(8'h00)) u_dut (
        .clk(clk), .rst(rst),
        .mem_req(mem_req), .mem_out(mem_out),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .halted(halted)
    );

    tb_mem u_mem (
        .clk(clk), .zero_latency(zero_latency),
        .mem_req(mem_req), .mem_out(mem_out),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("Timeout: the CPU did not halt within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_val(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    // Places one instruction, high byte first, and advances the load address.
    task automatic emit(input logic [3:0] op, input logic [3:0] r0, input logic [7:0] low);
        u_mem.write_byte(load_addr, {op, r0});
        u_mem.write_byte(load_addr + 8'd1, low);
        load_addr = load_addr + 8'd2;
    endtask

    task automatic begin_program(input logic fast);
        @(posedge clk);
        #1;
        rst          = 1'b0;
        zero_latency = fast;
        load_addr    = 8'h00;
        u_mem.fill();
    endtask

    task automatic run_program(input string name);
        repeat (3) @(posedge clk);
        #1;
        check_val({name, " reset"}, 8'h00, {5'd0, mem_out.we, mem_req, halted});
        rst = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (halted !== 1'b1);
    endtask

    task automatic test_lodi_str();
        begin_program(1'b1);
        emit(cpu_pkg::OP_LODI, 4'd1, 8'h5A);
        emit(cpu_pkg::OP_LODI, 4'd2, 8'hC3);
        emit(cpu_pkg::OP_STR, 4'd1, 8'h80);
        emit(cpu_pkg::OP_STR, 4'd2, 8'h81);
        emit(cpu_pkg::OP_HLT, 4'd0, 8'h00);
        run_program("lodi_str");
        check_val("lodi_str", 8'h5A, u_mem.read_byte(8'h80));
        check_val("lodi_str", 8'hC3, u_mem.read_byte(8'h81));
        // Halted holds and the bus falls quiet once the flushed read drains.
        repeat (8) @(posedge clk);
        #1;
        check_val("lodi_str halted", 8'h01, {6'd0, mem_req, halted});
    endtask

    task automatic test_add();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] sum;
        logic [7:0] b_inc;
        a     = 8'hF0;
        b     = 8'h25;
        sum   = a + b;
        b_inc = b + 8'h07;
        begin_program(1'b1);
        emit(cpu_pkg::OP_LODI, 4'd1, a);
        emit(cpu_pkg::OP_LODI, 4'd2, b);
        emit(cpu_pkg::OP_ADD, 4'd3, 8'h12);
        emit(cpu_pkg::OP_STR, 4'd3, 8'h90);
        emit(cpu_pkg::OP_ADDI, 4'd1, b);
        emit(cpu_pkg::OP_STR, 4'd1, 8'h91);
        emit(cpu_pkg::OP_ADDI, 4'd2, 8'h07);
        emit(cpu_pkg::OP_STR, 4'd2, 8'h92);
        emit(cpu_pkg::OP_HLT, 4'd0, 8'h00);
        run_program("add");
        check_val("add", sum, u_mem.read_byte(8'h90));
        check_val("addi wrap", sum, u_mem.read_byte(8'h91));
        check_val("addi", b_inc, u_mem.read_byte(8'h92));
    endtask

    task automatic load_nand_lod();
        u_mem.write_byte(8'hA0, LOD_DATA0);
        u_mem.write_byte(8'hA1, LOD_DATA1);
        emit(cpu_pkg::OP_LODI, 4'd4, 8'hCC);
        emit(cpu_pkg::OP_LODI, 4'd5, 8'hAA);
        emit(cpu_pkg::OP_NAND, 4'd6, 8'h45);
        emit(cpu_pkg::OP_STR, 4'd6, 8'hB0);
        emit(cpu_pkg::OP_LOD, 4'd7, 8'hA0);
        emit(cpu_pkg::OP_STR, 4'd7, 8'hB1);
        emit(cpu_pkg::OP_LOD, 4'd8, 8'hA1);
        emit(cpu_pkg::OP_ADD, 4'd9, 8'h78);
        emit(cpu_pkg::OP_STR, 4'd9, 8'hB2);
        emit(cpu_pkg::OP_HLT, 4'd0, 8'h00);
    endtask

    task automatic check_nand_lod(input string name);
        logic [7:0] nand_exp;
        logic [7:0] sum_exp;
        nand_exp = ~(8'hCC & 8'hAA);
        sum_exp  = LOD_DATA0 + LOD_DATA1;
        check_val({name, " nand"}, nand_exp, u_mem.read_byte(8'hB0));
        check_val({name, " lod"}, LOD_DATA0, u_mem.read_byte(8'hB1));
        check_val({name, " lod add"}, sum_exp, u_mem.read_byte(8'hB2));
    endtask

    // JMP skips a store, then a JEQZ loop adds 3 while counting r2 down to zero.
    task automatic load_branch();
        u_mem.write_byte(8'hC0, SKIP_PRESET);
        emit(cpu_pkg::OP_LODI, 4'd1, 8'h11);
        emit(cpu_pkg::OP_JMP, 4'd0, 8'h06);
        emit(cpu_pkg::OP_STR, 4'd1, 8'hC0);
        emit(cpu_pkg::OP_LODI, 4'd2, 8'd5);
        emit(cpu_pkg::OP_LODI, 4'd3, 8'd0);
        emit(cpu_pkg::OP_LODI, 4'd4, 8'hFF);
        emit(cpu_pkg::OP_JEQZ, 4'd2, 8'h14);
        emit(cpu_pkg::OP_ADDI, 4'd3, 8'd3);
        emit(cpu_pkg::OP_ADD, 4'd2, 8'h24);
        emit(cpu_pkg::OP_JMP, 4'd0, 8'h0C);
        // Unassigned opcode; if it acted like ADD it would overwrite r3.
        emit(4'hB, 4'd3, 8'h12);
        emit(cpu_pkg::OP_STR, 4'd3, 8'hC1);
        emit(cpu_pkg::OP_STR, 4'd2, 8'hC2);
        emit(cpu_pkg::OP_STR, 4'd1, 8'hC3);
        emit(cpu_pkg::OP_HLT, 4'd0, 8'h00);
    endtask

    task automatic check_branch(input string name);
        logic [7:0] acc;
        logic [7:0] count;
        acc   = 8'd0;
        count = 8'd5;
        while (count != 8'd0) begin
            acc   = acc + 8'd3;
            count = count - 8'd1;
        end
        check_val({name, " skipped store"}, SKIP_PRESET, u_mem.read_byte(8'hC0));
        check_val({name, " loop total"}, acc, u_mem.read_byte(8'hC1));
        check_val({name, " counter"}, count, u_mem.read_byte(8'hC2));
        check_val({name, " r1 kept"}, 8'h11, u_mem.read_byte(8'hC3));
    endtask

    task automatic test_nand_lod();
        begin_program(1'b1);
        load_nand_lod();
        run_program("nand_lod");
        check_nand_lod("nand_lod");
    endtask

    task automatic test_branch();
        begin_program(1'b1);
        load_branch();
        run_program("branch");
        check_branch("branch");
    endtask

    // Same programs with random memory latency, so the bus stalls often.
    task automatic test_latency();
        begin_program(1'b0);
        load_nand_lod();
        run_program("latency nand_lod");
        check_nand_lod("latency nand_lod");
        begin_program(1'b0);
        load_branch();
        run_program("latency branch");
        check_branch("latency branch");
    endtask

    initial begin
        rst          = 1'b0;
        zero_latency = 1'b1;
        load_addr    = 8'h00;
        test_lodi_str();
        test_add();
        test_nand_lod();
        test_branch();
        test_latency();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: src.f
cpu_pkg.sv
fetch_unit.sv
exec_unit.sv
mem_arbiter.sv
cpu_control.sv
eightbit_cpu.sv
tb_mem.sv
tb_eightbit.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_eightbit \
    -f src.f -o sim_eightbit || exit 1
./obj_dir/sim_eightbit > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
